// File: compile.f
+incdir+tb
logic/lcd_debug_pkg.sv
logic/lcd_byte_if.sv
logic/lcd_delay_timer.sv
logic/lcd_nibble_writer.sv
logic/debug_text_builder.sv
logic/lcd_sequencer.sv
logic/lcd_debug_top.sv
tb/lcd_debug_tb.sv

// File: logic/debug_text_builder.sv
`timescale 1ns/1ps
`default_nettype none

module debug_text_builder (
	input  wire [3:0]                            column,
	input  wire                                  ram_view,
	input  wire [7:0]                            ram_addr,
	input  wire [7:0]                            ram_data,
	input  wire [8*lcd_debug_pkg::NUM_REGS-1:0] cpu_regs,
	input  wire [3:0]                            reg_sel,
	output logic [7:0]                           column_char
);
	logic [7:0]  reg_byte;
	logic [7:0]  shown_byte;	// Printed in columns 7 and 8
	logic [15:0] mode_pair;
	logic [15:0] label_pair;	// Columns 4 and 5

	// ASCII hex digit, 0-9 then A-F
	function automatic logic [7:0] hex_char(input logic [3:0] n);
		if (n <= 4'd9) begin
			hex_char = 8'h30 + {4'h0, n};
		end else begin
			hex_char = 8'h37 + {4'h0, n};
		end
	endfunction

	// Byte of the selected CPU register
	always_comb begin
		reg_byte = 8'h00;	// Selects past the last register show 00
		for (int i = 0; i < lcd_debug_pkg::NUM_REGS; i++) begin
			if (reg_sel == 4'(i)) begin
				reg_byte = cpu_regs[8*i +: 8];
			end
		end
	end

	assign mode_pair = ram_view ? "RM" : "PC";
	assign shown_byte = ram_view ? ram_data : reg_byte;

	always_comb begin
		if (ram_view) begin
			label_pair = {hex_char(ram_addr[7:4]), hex_char(ram_addr[3:0])};
		end else begin
			label_pair = lcd_debug_pkg::REG_NAMES[reg_sel];
		end
	end

	// Column 0 is the home command, its character is never sent
	always_comb begin
		case (column)
			4'd1:    column_char = mode_pair[15:8];
			4'd2:    column_char = mode_pair[7:0];
			4'd4:    column_char = label_pair[15:8];
			4'd5:    column_char = label_pair[7:0];
			4'd7:    column_char = hex_char(shown_byte[7:4]);
			4'd8:    column_char = hex_char(shown_byte[3:0]);
			default: column_char = lcd_debug_pkg::CHAR_SPACE;	// Gaps at 3 and 6
		endcase
	end

endmodule

`default_nettype wire

// File: logic/lcd_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lcd_byte_if;
	logic       start;	// One-cycle request
	logic [7:0] value;
	logic       rs;	// 0 command, 1 data
	logic       single;	// Send the high nibble only
	logic       done;	// One-cycle completion

	modport sender (
		output start,
		output value,
		output rs,
		output single,
		input  done
	);

	modport writer (
		input  start,
		input  value,
		input  rs,
		input  single,
		output done
	);
endinterface

`default_nettype wire

// File: logic/lcd_debug_pkg.sv
`default_nettype none

package lcd_debug_pkg;

	// Sequencer phases
	typedef enum logic [1:0] {
		POWER_ON = 2'd0,
		CONFIG   = 2'd1,
		SETTLE   = 2'd2,
		REFRESH  = 2'd3
	} seq_state_t;

	localparam int TIMER_WIDTH = 22;	// Enough for the power-on wait
	localparam int LINE_LEN = 8;
	localparam int NUM_REGS = 12;

	localparam logic [7:0] CHAR_SPACE = 8'h20;
	localparam logic [7:0] CMD_HOME = 8'h80;	// DDRAM address 0

	// Wake-up in 8-bit mode, then switch to 4-bit
	localparam logic [3:0] INIT_NIBBLES [4] = '{4'h3, 4'h3, 4'h3, 4'h2};

	localparam logic [7:0] CONFIG_CMDS [4] = '{
		8'h28,	// Function set 4-bit two lines
		8'h06,	// Entry mode increment
		8'h0C,	// Display on without cursor
		8'h01	// Clear display
	};

	// Two ASCII letters per register select
	localparam logic [15:0] REG_NAMES [16] = '{
		"PC",
		"IR",
		"ST",
		"W ",
		"Z ",
		"A ",
		"B ",
		"C ",
		"SP",
		"AD",
		"DO",
		"DI",
		"--",
		"--",
		"--",
		"--"
	};

endpackage

`default_nettype wire

// File: logic/lcd_debug_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_debug_top #(
	parameter int POWER_ON_WAIT = 753664,
	parameter int INIT_WAIT = 212960,
	parameter int CLEAR_WAIT = 98304,
	parameter int BYTE_WAIT = 3968,
	parameter int STROBE_CYCLES = 16
) (
	input  wire                                  qzt_clk,
	input  wire                                  rst_n,
	input  wire                                  ram_view,
	input  wire [7:0]                            ram_addr,
	input  wire [7:0]                            ram_data,
	input  wire [8*lcd_debug_pkg::NUM_REGS-1:0] cpu_regs,
	input  wire [3:0]                            reg_sel,
	output logic                                 lcd_rs,
	output logic                                 lcd_e,
	output logic [3:0]                           lcd_data
);
	logic                                  timer_load;
	logic [lcd_debug_pkg::TIMER_WIDTH-1:0] timer_value;
	logic                                  timer_expired;
	logic [3:0]                            column;
	logic [7:0]                            column_char;

	lcd_byte_if byte_bus ();

	lcd_sequencer #(
		.POWER_ON_WAIT (POWER_ON_WAIT),
		.INIT_WAIT     (INIT_WAIT),
		.CLEAR_WAIT    (CLEAR_WAIT),
		.BYTE_WAIT     (BYTE_WAIT)
	) u_sequencer (
		.qzt_clk       (qzt_clk),
		.rst_n         (rst_n),
		.byte_bus      (byte_bus.sender),
		.timer_load    (timer_load),
		.timer_value   (timer_value),
		.timer_expired (timer_expired),
		.column        (column),
		.column_char   (column_char)
	);

	lcd_delay_timer #(
		.TIMER_WIDTH (lcd_debug_pkg::TIMER_WIDTH)
	) u_delay_timer (
		.qzt_clk (qzt_clk),
		.rst_n   (rst_n),
		.load    (timer_load),
		.value   (timer_value),
		.expired (timer_expired)
	);

	lcd_nibble_writer #(
		.STROBE_CYCLES (STROBE_CYCLES)
	) u_nibble_writer (
		.qzt_clk  (qzt_clk),
		.rst_n    (rst_n),
		.byte_bus (byte_bus.writer),
		.lcd_rs   (lcd_rs),
		.lcd_e    (lcd_e),
		.lcd_data (lcd_data)
	);

	debug_text_builder u_text_builder (
		.column      (column),
		.ram_view    (ram_view),
		.ram_addr    (ram_addr),
		.ram_data    (ram_data),
		.cpu_regs    (cpu_regs),
		.reg_sel     (reg_sel),
		.column_char (column_char)
	);

endmodule

`default_nettype wire

// File: logic/lcd_delay_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_delay_timer #(
	parameter int TIMER_WIDTH = 22
) (
	input  wire                   qzt_clk,
	input  wire                   rst_n,
	input  wire                   load,
	input  wire [TIMER_WIDTH-1:0] value,
	output logic                  expired
);
	logic [TIMER_WIDTH-1:0] count;

	// Down-counter that parks at zero
	always_ff @(posedge qzt_clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= value;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// High N cycles after a load of N
	assign expired = (count == '0);

endmodule

`default_nettype wire

// File: logic/lcd_nibble_writer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_nibble_writer #(
	parameter int STROBE_CYCLES = 16
) (
	input  wire        qzt_clk,
	input  wire        rst_n,
	lcd_byte_if.writer byte_bus,
	output logic       lcd_rs,
	output logic       lcd_e,
	output logic [3:0] lcd_data
);
	// Setup, strobe and hold, plus one cycle to present the nibble
	localparam int PHASE_END = 3 * STROBE_CYCLES;
	localparam int CNT_W = $clog2(PHASE_END + 1);

	logic             busy;
	logic             low_half;	// Working on the low nibble
	logic [CNT_W-1:0] phase_cnt;

	always_ff @(posedge qzt_clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			low_half <= 1'b0;
			phase_cnt <= '0;
			lcd_rs <= 1'b0;
			lcd_e <= 1'b0;
			lcd_data <= 4'h0;
			byte_bus.done <= 1'b0;
		end else begin
			byte_bus.done <= 1'b0;
			if (byte_bus.start) begin
				busy <= 1'b1;
				low_half <= 1'b0;
				phase_cnt <= '0;
				lcd_rs <= byte_bus.rs;	// Held for the whole transfer
			end else if (busy) begin
				phase_cnt <= phase_cnt + 1'b1;

				if (phase_cnt == '0) begin
					lcd_data <= low_half ? byte_bus.value[3:0] : byte_bus.value[7:4];
				end

				if (phase_cnt == CNT_W'(STROBE_CYCLES)) begin
					lcd_e <= 1'b1;
				end

				if (phase_cnt == CNT_W'(2 * STROBE_CYCLES)) begin
					lcd_e <= 1'b0;	// Data stays for the hold time
				end

				if (phase_cnt == CNT_W'(PHASE_END)) begin
					phase_cnt <= '0;
					if (!low_half && !byte_bus.single) begin
						low_half <= 1'b1;
					end else begin
						// Transfer finished, release the bus
						busy <= 1'b0;
						lcd_data <= 4'h0;
						lcd_rs <= 1'b0;
						byte_bus.done <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/lcd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer #(
	parameter int POWER_ON_WAIT = 753664,
	parameter int INIT_WAIT = 212960,
	parameter int CLEAR_WAIT = 98304,
	parameter int BYTE_WAIT = 3968
) (
	input  wire                                   qzt_clk,
	input  wire                                   rst_n,
	lcd_byte_if.sender                            byte_bus,
	output logic                                  timer_load,
	output logic [lcd_debug_pkg::TIMER_WIDTH-1:0] timer_value,
	input  wire                                   timer_expired,
	output logic [3:0]                            column,
	input  wire  [7:0]                            column_char
);
	localparam int TW = lcd_debug_pkg::TIMER_WIDTH;

	lcd_debug_pkg::seq_state_t state;
	lcd_debug_pkg::seq_state_t nxt_state;
	lcd_debug_pkg::seq_state_t pick_state;
	logic [3:0]    step;
	logic [3:0]    nxt_step;
	logic [3:0]    pick_step;
	logic          arm;	// Power-on wait not loaded yet
	logic          sending;
	logic          finished;
	logic          has_wait;
	logic [TW-1:0] wait_len;
	logic          issue;
	logic [7:0]    pick_value;
	logic          pick_rs;
	logic          pick_single;

	assign finished = sending && byte_bus.done;

	// Step after the current one and the wait between them
	always_comb begin
		nxt_state = state;
		nxt_step = step + 4'd1;
		has_wait = 1'b1;
		wait_len = TW'(BYTE_WAIT);
		case (state)
			lcd_debug_pkg::POWER_ON: begin
				wait_len = TW'(INIT_WAIT);
				if (step == 4'd3) begin
					nxt_state = lcd_debug_pkg::CONFIG;
					nxt_step = 4'd0;
					has_wait = 1'b0;	// First command follows the last nibble
				end
			end
			lcd_debug_pkg::CONFIG: begin
				if (step == 4'd3) begin
					nxt_state = lcd_debug_pkg::SETTLE;
					nxt_step = 4'd0;
					wait_len = TW'(CLEAR_WAIT);
				end
			end
			lcd_debug_pkg::REFRESH: begin
				if (step == 4'(lcd_debug_pkg::LINE_LEN)) begin
					nxt_step = 4'd0;
				end
			end
			default: ;
		endcase
	end

	// Transfer to launch, looking one step ahead when a byte completes
	always_comb begin
		if (finished) begin
			pick_state = nxt_state;
			pick_step = nxt_step;
		end else begin
			pick_state = state;
			pick_step = step;
		end
	end

	assign column = pick_step;

	always_comb begin
		pick_value = lcd_debug_pkg::CMD_HOME;
		pick_rs = 1'b0;
		pick_single = 1'b0;
		case (pick_state)
			lcd_debug_pkg::POWER_ON: begin
				pick_value = {lcd_debug_pkg::INIT_NIBBLES[pick_step[1:0]], 4'h0};
				pick_single = 1'b1;
			end
			lcd_debug_pkg::CONFIG: pick_value = lcd_debug_pkg::CONFIG_CMDS[pick_step[1:0]];
			default: begin
				// SETTLE leads into the home command as well
				if (pick_step != 4'd0) begin
					pick_value = column_char;
					pick_rs = 1'b1;
				end
			end
		endcase
	end

	assign issue = (finished && !has_wait) || (!sending && !arm && timer_expired);

	assign timer_load = arm || (finished && has_wait);
	assign timer_value = arm ? TW'(POWER_ON_WAIT) : wait_len;

	always_ff @(posedge qzt_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= lcd_debug_pkg::POWER_ON;
			step <= 4'd0;
			arm <= 1'b1;
			sending <= 1'b0;
			byte_bus.start <= 1'b0;
		end else begin
			arm <= 1'b0;
			byte_bus.start <= issue;
			if (finished) begin
				state <= nxt_state;
				step <= nxt_step;
				sending <= !has_wait;
			end else if (issue) begin
				sending <= 1'b1;
				if (state == lcd_debug_pkg::SETTLE) begin
					state <= lcd_debug_pkg::REFRESH;
					step <= 4'd0;
				end
			end
		end
	end

	// Transfer contents, held until done
	always_ff @(posedge qzt_clk) begin
		if (issue) begin
			byte_bus.value <= pick_value;
			byte_bus.rs <= pick_rs;
			byte_bus.single <= pick_single;
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lcd_debug_tb -f compile.f \
	&& ./obj_dir/Vlcd_debug_tb | tee /dev/stderr | grep -q "^all tests passed$" \
	&& echo "Simulation PASSED" && exit 0 \
	|| { echo "Simulation FAILED"; exit 1; }

// File: tb/lcd_debug_ref.svh
`ifndef LCD_DEBUG_REF_SVH
`define LCD_DEBUG_REF_SVH

// ASCII hex digit
function automatic logic [7:0] hex_char(input logic [3:0] n);
	return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n};
endfunction

// Register label, "--" past the twelfth register
function automatic logic [15:0] reg_name(input logic [3:0] sel);
	logic [191:0] names;
	names = "PCIRSTW Z A B C SPADDODI";	// PC in the top two letters
	if (sel > 4'd11) begin
		return "--";
	end
	return names[16 * (11 - int'(sel)) +: 16];
endfunction

// Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// {rs, byte} expected at a stream position counted from reset
function automatic logic [8:0] expected_byte(input int index, input logic mode,
		input logic [7:0] addr, input logic [7:0] data, input logic [95:0] regs,
		input logic [3:0] sel);
	logic [7:0]  cmds [8];
	logic [7:0]  shown;
	logic [15:0] pair;
	logic [15:0] label;
	int          col;
	cmds = '{8'h03, 8'h03, 8'h03, 8'h02, 8'h28, 8'h06, 8'h0C, 8'h01};	// Init nibbles, config
	if (index < 8) begin
		return {1'b0, cmds[index]};
	end
	col = (index - 8) % 9;
	pair = mode ? "RM" : "PC";
	shown = mode ? data : ((sel < 4'd12) ? regs[8 * int'(sel) +: 8] : 8'h00);
	label = mode ? {hex_char(addr[7:4]), hex_char(addr[3:0])} : reg_name(sel);
	case (col)
		0: return {1'b0, 8'h80};	// Home command
		1: return {1'b1, pair[15:8]};
		2: return {1'b1, pair[7:0]};
		4: return {1'b1, label[15:8]};
		5: return {1'b1, label[7:0]};
		7: return {1'b1, hex_char(shown[7:4])};
		8: return {1'b1, hex_char(shown[3:0])};
		default: return {1'b1, 8'h20};	// Spaces at 3 and 6
	endcase
endfunction

`endif

// File: tb/lcd_debug_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_debug_tb;
	localparam int POWER_ON_WAIT = 40;
	localparam int INIT_WAIT = 20;
	localparam int CLEAR_WAIT = 30;
	localparam int BYTE_WAIT = 8;
	localparam int STROBE_CYCLES = 2;
	localparam int RAM_FRAMES = 8;
	localparam int CPU_FRAMES = 16;
	localparam int RESTART_FRAMES = 2;
	// Transfer lengths plus handshake slack
	localparam int NIBBLE_CYCLES = 3 * STROBE_CYCLES + 1 + 4;
	localparam int BYTE_CYCLES = 6 * STROBE_CYCLES + 2 + 4;
	localparam int STARTUP_CYCLES = 8 + POWER_ON_WAIT + 4 * NIBBLE_CYCLES + 3 * INIT_WAIT
		+ 4 * BYTE_CYCLES + 3 * BYTE_WAIT + CLEAR_WAIT;
	localparam int FRAME_CYCLES = 9 * (BYTE_CYCLES + BYTE_WAIT);
	// Two start-ups and all frames including the cut one plus 25%
	localparam int CYCLE_LIMIT = (2 * STARTUP_CYCLES
		+ (RAM_FRAMES + CPU_FRAMES + RESTART_FRAMES + 1) * FRAME_CYCLES) * 5 / 4;

	logic        qzt_clk;
	logic        rst_n;
	logic        ram_view;
	logic [7:0]  ram_addr;
	logic [7:0]  ram_data;
	logic [95:0] cpu_regs;
	logic [3:0]  reg_sel;
	wire         lcd_rs;
	wire         lcd_e;
	wire  [3:0]  lcd_data;

	logic [15:0] lfsr_state = 16'd65;
	string       test_name = "ram_view";
	int          err_count = 0;
	int          check_count = 0;
	int          frames_checked = 0;
	int          stream_idx = 0;	// Bytes compared since reset
	logic        timed_out = 1'b0;
	logic        e_prev = 1'b0;
	logic        hi_pending = 1'b0;
	logic [4:0]  hi_half = '0;	// rs and high nibble
	int          nib_count = 0;
	logic [8:0]  seen_q [$];

	`include "lcd_debug_ref.svh"

	lcd_debug_top #(
		.POWER_ON_WAIT (POWER_ON_WAIT),
		.INIT_WAIT     (INIT_WAIT),
		.CLEAR_WAIT    (CLEAR_WAIT),
		.BYTE_WAIT     (BYTE_WAIT),
		.STROBE_CYCLES (STROBE_CYCLES)
	) i_lcd_debug_top (
		.qzt_clk  (qzt_clk),
		.rst_n    (rst_n),
		.ram_view (ram_view),
		.ram_addr (ram_addr),
		.ram_data (ram_data),
		.cpu_regs (cpu_regs),
		.reg_sel  (reg_sel),
		.lcd_rs   (lcd_rs),
		.lcd_e    (lcd_e),
		.lcd_data (lcd_data)
	);

	always #2 qzt_clk = ~qzt_clk;

	// Bus monitor samples each lcd_e fall half a clock later
	always @(negedge qzt_clk) begin
		if (!rst_n) begin
			e_prev = 1'b0;
			hi_pending = 1'b0;
			nib_count = 0;
			seen_q.delete();
		end else begin
			if (e_prev && !lcd_e) begin
				if (nib_count < 4) begin
					seen_q.push_back({lcd_rs, 4'h0, lcd_data});	// Init nibbles come alone
					nib_count++;
				end else if (!hi_pending) begin
					hi_half = {lcd_rs, lcd_data};
					hi_pending = 1'b1;
				end else begin
					assert (lcd_rs == hi_half[4]) else begin
						$display("lcd_rs changed between the two nibbles of byte %0d", stream_idx);
						err_count++;
					end
					seen_q.push_back({hi_half, lcd_data});
					hi_pending = 1'b0;
				end
			end
			e_prev = lcd_e;
		end
	end

	// Compares each captured byte with the reference stream
	always @(posedge qzt_clk) begin
		logic [8:0] got;
		logic [8:0] want;
		string      name;
		if (!rst_n) begin
			stream_idx = 0;
		end else begin
			while (seen_q.size() > 0) begin
				got = seen_q.pop_front();
				want = expected_byte(stream_idx, ram_view, ram_addr, ram_data, cpu_regs, reg_sel);
				name = (stream_idx < 4) ? "init_nibbles" :
					(stream_idx < 8) ? "config_cmds" : test_name;
				check_count++;
				assert (got == want) else begin
					$display("ERR %s byte %0d expected rs=%0b %h actual rs=%0b %h",
						name, stream_idx, want[8], want[7:0], got[8], got[7:0]);
					err_count++;
				end
				if (stream_idx >= 16 && (stream_idx - 16) % 9 == 0) begin
					frames_checked++;	// Last column of a frame
				end
				stream_idx++;
			end
		end
	end

	// Reset for 8 cycles and expect lcd_e low through the power-on wait
	task automatic reset_and_check_idle();
		@(negedge qzt_clk);
		rst_n = 1'b0;
		repeat (8) begin
			@(negedge qzt_clk);
			assert (!lcd_e && !lcd_rs && lcd_data == 4'h0) else begin
				$display("LCD outputs are not low while reset is asserted");
				err_count++;
			end
		end
		rst_n = 1'b1;
		repeat (POWER_ON_WAIT) begin
			@(negedge qzt_clk);
			assert (!lcd_e) else begin
				$display("lcd_e rose before the power-on wait was over");
				err_count++;
			end
		end
	endtask

	task automatic wait_frames(input int count);
		int target;
		target = frames_checked + count;
		while (frames_checked < target) begin
			@(negedge qzt_clk);
		end
	endtask

	task automatic draw_bits(input int n, output logic [95:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic report_and_finish();
		$display("Summary: %0d checks, %0d errors, %0d frames", check_count, err_count,
			frames_checked);
		if (err_count == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	initial begin
		logic [95:0] bits;
		int          frame_start;
		qzt_clk = 1'b0;
		rst_n = 1'b0;
		ram_view = 1'b1;
		ram_addr = 8'hAB;	// Letter digits in the first two frames
		ram_data = 8'hCD;
		cpu_regs = '0;
		reg_sel = 4'd0;
		reset_and_check_idle();
		wait_frames(1);
		ram_addr = 8'hEF;
		ram_data = 8'h9A;
		wait_frames(1);
		for (int k = 2; k < RAM_FRAMES; k++) begin
			draw_bits(16, bits);
			ram_addr = bits[7:0];
			ram_data = bits[15:8];
			wait_frames(1);
		end
		test_name = "cpu_view";
		ram_view = 1'b0;
		draw_bits(96, bits);
		cpu_regs = bits;
		for (int s = 0; s < CPU_FRAMES; s++) begin
			reg_sel = 4'(s);
			wait_frames(1);
		end
		// Cut the next frame while the strobe of its fifth byte is high
		test_name = "reset_restart";
		frame_start = stream_idx;
		while (stream_idx < frame_start + 4) begin
			@(negedge qzt_clk);
		end
		while (!lcd_e) begin
			@(negedge qzt_clk);
		end
		reset_and_check_idle();
		wait_frames(RESTART_FRAMES);
		report_and_finish();
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge qzt_clk);
			cycles++;
		end
		timed_out = 1'b1;
		$display("Timeout after %0d cycles, the LCD stream stopped before the last frame",
			cycles);
		report_and_finish();
	end

endmodule

`default_nettype wire
